// File: design/basics_pkg.sv
package basics_pkg;

	// Command bytes, upper case for queries and lower case for sets
	localparam logic [7:0] cmd_version = 8'h76;
	localparam logic [7:0] cmd_query_i2c = 8'h49;
	localparam logic [7:0] cmd_set_i2c = 8'h69;
	localparam logic [7:0] cmd_query_gpio = 8'h47;
	localparam logic [7:0] cmd_set_gpio = 8'h67;
	localparam logic [7:0] cmd_query_mbus = 8'h4D;
	localparam logic [7:0] cmd_set_mbus = 8'h6D;

	// First byte of every reply frame
	localparam logic [7:0] reply_ack = 8'h00;
	localparam logic [7:0] reply_nak = 8'h01;

	// What follows the reply header
	localparam logic [1:0] kind_none = 2'd0;
	localparam logic [1:0] kind_version = 2'd1;
	localparam logic [1:0] kind_value = 2'd2;

	// Selector bytes, only meaningful inside their own command family
	localparam logic [7:0] sel_i2c_speed = 8'h63;
	localparam logic [7:0] sel_i2c_addr = 8'h61;
	localparam logic [7:0] sel_gpio_level = 8'h6C;
	localparam logic [7:0] sel_gpio_dir = 8'h64;
	localparam logic [7:0] sel_mbus_addr = 8'h6C;
	localparam logic [7:0] sel_mbus_div = 8'h63;

	// Built-in version
	localparam logic [7:0] version_major = 8'h00;
	localparam logic [7:0] version_minor = 8'h02;

	// Slot table, same order as the selectors above
	localparam int num_slots = 6;
	localparam int slot_index_w = 3;
	localparam int slot_width [num_slots] = '{8, 16, 24, 24, 20, 22};
	localparam logic [23:0] slot_reset [num_slots] = '{
		24'd99,
		24'h00FFFF,
		24'h000000,
		24'h000000,
		24'h000000,
		24'h000001
	};
	localparam int slot_bytes [num_slots] = '{1, 2, 3, 3, 3, 3};

	// Output message FIFO
	localparam int fifo_depth = 16;
	localparam int fifo_addr_w = $clog2(fifo_depth);

endpackage

// File: design/frame_receiver.sv
`timescale 1ns/1ps

module frame_receiver (
	input logic clk,
	input logic rst,
	input logic [7:0] in_data,
	input logic in_data_valid,
	input logic in_frame_valid,
	output logic cmd_strobe,
	output logic eid_strobe,
	output logic len_strobe,
	output logic payload_strobe,
	output logic [7:0] byte_data,
	output logic frame_end
);

	logic frame_valid_d;
	logic frame_start;
	logic take;
	// Byte position in the frame, 3 means payload
	logic [1:0] pos;
	logic [1:0] index;

	assign frame_start = in_frame_valid && !frame_valid_d;
	assign take = in_frame_valid && in_data_valid;

	// A fresh frame always starts at the command byte
	assign index = frame_start ? 2'd0 : pos;

	always_ff @(posedge clk) begin
		if (rst) begin
			frame_valid_d <= 1'b0;
			pos <= 2'd0;
			cmd_strobe <= 1'b0;
			eid_strobe <= 1'b0;
			len_strobe <= 1'b0;
			payload_strobe <= 1'b0;
			frame_end <= 1'b0;
		end else begin
			frame_valid_d <= in_frame_valid;
			cmd_strobe <= take && index == 2'd0;
			eid_strobe <= take && index == 2'd1;
			len_strobe <= take && index == 2'd2;
			payload_strobe <= take && index == 2'd3;
			frame_end <= frame_valid_d && !in_frame_valid;
			if (take && index != 2'd3) begin
				pos <= index + 2'd1;
			end else if (frame_start) begin
				pos <= 2'd0;
			end
		end
	end

	// Byte travels alongside its strobe
	always_ff @(posedge clk) begin
		byte_data <= in_data;
	end

endmodule

// File: design/basics_controller.sv
`timescale 1ns/1ps

module basics_controller (
	input logic clk,
	input logic rst,
	input logic cmd_strobe,
	input logic eid_strobe,
	input logic len_strobe,
	input logic payload_strobe,
	input logic [7:0] byte_data,
	input logic frame_end,
	input logic reply_busy,
	output logic [basics_pkg::slot_index_w-1:0] slot_sel,
	output logic stage_shift,
	output logic [7:0] stage_byte,
	output logic commit,
	output logic reply_start,
	output logic [7:0] reply_code,
	output logic [7:0] reply_eid,
	output logic [1:0] reply_kind,
	output logic [basics_pkg::slot_index_w-1:0] reply_slot
);

	typedef enum logic [2:0] {
		st_idle,
		st_eid,
		st_len,
		st_body,
		st_reply,
		st_ignore
	} state_t;

	state_t state;
	state_t next_state;

	logic [7:0] cmd_reg;
	logic [7:0] eid_reg;
	logic [15:0] version_in;
	logic [basics_pkg::slot_index_w-1:0] slot_reg;
	logic [basics_pkg::slot_index_w-1:0] sel_slot;
	logic sel_hit;
	logic sel_ok;
	// Payload bytes seen, selector included, saturating
	logic [3:0] pay_count;
	logic [3:0] set_count;
	logic is_version;
	logic is_query;
	logic is_set;
	logic take_byte;

	assign is_version = cmd_reg == basics_pkg::cmd_version;
	assign is_query = cmd_reg inside {basics_pkg::cmd_query_i2c, basics_pkg::cmd_query_gpio,
		basics_pkg::cmd_query_mbus};
	assign is_set = cmd_reg inside {basics_pkg::cmd_set_i2c, basics_pkg::cmd_set_gpio,
		basics_pkg::cmd_set_mbus};
	assign take_byte = state == st_body && payload_strobe;
	assign set_count = 4'(basics_pkg::slot_bytes[slot_reg] + 1);

	// Selector lookup within the command family
	always_comb begin
		sel_hit = 1'b0;
		sel_slot = '0;
		case (cmd_reg)
			basics_pkg::cmd_query_i2c, basics_pkg::cmd_set_i2c: begin
				if (byte_data == basics_pkg::sel_i2c_speed) begin
					sel_hit = 1'b1;
					sel_slot = 3'd0;
				end else if (byte_data == basics_pkg::sel_i2c_addr) begin
					sel_hit = 1'b1;
					sel_slot = 3'd1;
				end
			end
			basics_pkg::cmd_query_gpio, basics_pkg::cmd_set_gpio: begin
				if (byte_data == basics_pkg::sel_gpio_level) begin
					sel_hit = 1'b1;
					sel_slot = 3'd2;
				end else if (byte_data == basics_pkg::sel_gpio_dir) begin
					sel_hit = 1'b1;
					sel_slot = 3'd3;
				end
			end
			basics_pkg::cmd_query_mbus, basics_pkg::cmd_set_mbus: begin
				if (byte_data == basics_pkg::sel_mbus_addr) begin
					sel_hit = 1'b1;
					sel_slot = 3'd4;
				end else if (byte_data == basics_pkg::sel_mbus_div) begin
					sel_hit = 1'b1;
					sel_slot = 3'd5;
				end
			end
			default: begin
				sel_hit = 1'b0;
			end
		endcase
	end

	always_comb begin
		next_state = state;
		case (state)
			st_idle: begin
				// Frames arriving mid-reply are dropped without an answer
				if (cmd_strobe) begin
					next_state = reply_busy ? st_ignore : st_eid;
				end
			end
			st_eid: begin
				if (frame_end) begin
					next_state = st_reply;
				end else if (eid_strobe) begin
					next_state = st_len;
				end
			end
			st_len: begin
				if (frame_end) begin
					next_state = st_reply;
				end else if (len_strobe) begin
					next_state = st_body;
				end
			end
			st_body: begin
				if (frame_end) begin
					next_state = st_reply;
				end
			end
			st_reply: next_state = st_idle;
			st_ignore: begin
				if (frame_end) begin
					next_state = st_idle;
				end
			end
			default: next_state = st_idle;
		endcase
	end

	// Reply decision, valid in st_reply only
	always_comb begin
		reply_code = basics_pkg::reply_nak;
		reply_kind = basics_pkg::kind_none;
		commit = 1'b0;
		if (is_version) begin
			if (pay_count == 4'd2 &&
					version_in == {basics_pkg::version_major, basics_pkg::version_minor}) begin
				reply_code = basics_pkg::reply_ack;
			end else begin
				reply_kind = basics_pkg::kind_version;
			end
		end else if (is_query && sel_ok && pay_count == 4'd1) begin
			reply_code = basics_pkg::reply_ack;
			reply_kind = basics_pkg::kind_value;
		end else if (is_set && sel_ok && pay_count == set_count) begin
			reply_code = basics_pkg::reply_ack;
			commit = state == st_reply;
		end
	end

	assign reply_start = state == st_reply;
	assign reply_eid = eid_reg;
	assign reply_slot = slot_reg;
	assign slot_sel = slot_reg;
	assign stage_byte = byte_data;
	assign stage_shift = take_byte && is_set && sel_ok && pay_count != 4'd0;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			sel_ok <= 1'b0;
			pay_count <= 4'd0;
		end else begin
			state <= next_state;
			if (cmd_strobe) begin
				sel_ok <= 1'b0;
				pay_count <= 4'd0;
			end else if (take_byte) begin
				if (pay_count != 4'hF) begin
					pay_count <= pay_count + 4'd1;
				end
				if (pay_count == 4'd0) begin
					sel_ok <= sel_hit;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_strobe) begin
			cmd_reg <= byte_data;
		end
		if (state == st_eid && eid_strobe) begin
			eid_reg <= byte_data;
		end
		if (take_byte) begin
			version_in <= {version_in[7:0], byte_data};
			if (pay_count == 4'd0) begin
				slot_reg <= sel_slot;
			end
		end
	end

	a_commit_not_shift: assert property (@(posedge clk) disable iff (rst)
		!(commit && stage_shift));

	a_state_legal: assert property (@(posedge clk) disable iff (rst)
		state inside {st_idle, st_eid, st_len, st_body, st_reply, st_ignore});

endmodule

// File: design/setting_slot.sv
`timescale 1ns/1ps

module setting_slot #(
	parameter int width = 8,
	parameter logic [23:0] reset_value = '0
) (
	input logic clk,
	input logic rst,
	input logic shift,
	input logic commit,
	input logic [7:0] shift_byte,
	output logic [width-1:0] value
);

	// Whole bytes, so an exact-length set replaces every staged bit
	localparam int stage_w = ((width + 7) / 8) * 8;

	logic [stage_w-1:0] staging;

	// New byte enters at the bottom, oldest byte drops off the top
	always_ff @(posedge clk) begin
		if (shift) begin
			staging <= stage_w'({staging, shift_byte});
		end
	end

	// Upper bits beyond the slot width are discarded here
	always_ff @(posedge clk) begin
		if (rst) begin
			value <= reset_value[width-1:0];
		end else if (commit) begin
			value <= staging[width-1:0];
		end
	end

	a_shift_commit_apart: assert property (@(posedge clk) disable iff (rst)
		!(shift && commit));

endmodule

// File: design/response_builder.sv
`timescale 1ns/1ps

module response_builder (
	input logic clk,
	input logic rst,
	input logic reply_start,
	input logic [7:0] reply_code,
	input logic [7:0] reply_eid,
	input logic [1:0] reply_kind,
	input logic [basics_pkg::slot_index_w-1:0] reply_slot,
	input logic [23:0] slot_value [basics_pkg::num_slots],
	input logic full,
	output logic [7:0] wr_data,
	output logic wr_last,
	output logic wr_en,
	output logic reply_busy
);

	logic [7:0] code_q;
	logic [7:0] eid_q;
	logic [1:0] kind_q;
	logic [basics_pkg::slot_index_w-1:0] slot_q;
	logic [1:0] len_q;
	logic [1:0] reply_len;
	// Byte index in the reply where the header is 0 to 2
	logic [2:0] step;
	logic [2:0] last_step;
	logic [2:0] bytes_left;
	logic [23:0] sel_value;
	logic [7:0] value_byte;

	always_comb begin
		case (reply_kind)
			basics_pkg::kind_version: reply_len = 2'd2;
			basics_pkg::kind_value: reply_len = 2'(basics_pkg::slot_bytes[reply_slot]);
			default: reply_len = 2'd0;
		endcase
	end

	assign last_step = 3'(len_q) + 3'd2;
	assign bytes_left = last_step - step;

	// Slot value goes out MSB byte first
	assign sel_value = slot_value[slot_q];
	assign value_byte = 8'(sel_value >> {bytes_left, 3'b000});

	always_comb begin
		case (step)
			3'd0: wr_data = code_q;
			3'd1: wr_data = eid_q;
			3'd2: wr_data = {6'd0, len_q};
			default: begin
				if (kind_q == basics_pkg::kind_version) begin
					wr_data = (step == 3'd3) ? basics_pkg::version_major :
						basics_pkg::version_minor;
				end else begin
					wr_data = value_byte;
				end
			end
		endcase
	end

	assign wr_en = reply_busy && !full;
	assign wr_last = step == last_step;

	always_ff @(posedge clk) begin
		if (rst) begin
			reply_busy <= 1'b0;
			step <= 3'd0;
		end else if (reply_start) begin
			reply_busy <= 1'b1;
			step <= 3'd0;
		end else if (wr_en) begin
			step <= step + 3'd1;
			if (wr_last) begin
				reply_busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reply_start) begin
			code_q <= reply_code;
			eid_q <= reply_eid;
			kind_q <= reply_kind;
			slot_q <= reply_slot;
			len_q <= reply_len;
		end
	end

	// The controller must hold new replies until this one is queued
	a_start_when_idle: assert property (@(posedge clk) disable iff (rst)
		reply_start |-> !reply_busy);

endmodule

// File: design/message_fifo.sv
`timescale 1ns/1ps

module message_fifo (
	input logic clk,
	input logic rst,
	input logic [7:0] wr_data,
	input logic wr_last,
	input logic wr_en,
	input logic out_ready,
	output logic full,
	output logic [7:0] out_data,
	output logic out_last,
	output logic out_valid
);

	localparam int aw = basics_pkg::fifo_addr_w;

	// Each entry is the last flag above the byte
	logic [8:0] mem [basics_pkg::fifo_depth];
	// One extra pointer bit tells full from empty
	logic [aw:0] wr_ptr;
	logic [aw:0] rd_ptr;
	logic empty;
	logic do_write;
	logic do_read;

	assign empty = wr_ptr == rd_ptr;
	assign full = wr_ptr[aw] != rd_ptr[aw] && wr_ptr[aw-1:0] == rd_ptr[aw-1:0];
	assign do_write = wr_en && !full;
	assign do_read = out_valid && out_ready;

	assign out_valid = !empty;
	assign {out_last, out_data} = mem[rd_ptr[aw-1:0]];

	always_ff @(posedge clk) begin
		if (do_write) begin
			mem[wr_ptr[aw-1:0]] <= {wr_last, wr_data};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_write) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_read) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		wr_en |-> !full);

	// Stalled output byte stays put until taken
	a_out_hold: assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last));

endmodule

// File: design/basics_top.sv
`timescale 1ns/1ps

module basics_top (
	input logic clk,
	input logic rst,
	input logic [7:0] in_data,
	input logic in_data_valid,
	input logic in_frame_valid,
	input logic out_ready,
	output logic [7:0] out_data,
	output logic out_last,
	output logic out_valid,
	output logic [7:0] i2c_speed,
	output logic [15:0] i2c_addr,
	output logic [23:0] gpio_level,
	output logic [23:0] gpio_direction,
	output logic [19:0] mbus_long_addr,
	output logic [21:0] mbus_clk_div
);

	logic cmd_strobe;
	logic eid_strobe;
	logic len_strobe;
	logic payload_strobe;
	logic [7:0] byte_data;
	logic frame_end;
	logic [basics_pkg::slot_index_w-1:0] slot_sel;
	logic stage_shift;
	logic [7:0] stage_byte;
	logic commit;
	logic reply_start;
	logic [7:0] reply_code;
	logic [7:0] reply_eid;
	logic [1:0] reply_kind;
	logic [basics_pkg::slot_index_w-1:0] reply_slot;
	logic reply_busy;
	logic [23:0] slot_value [basics_pkg::num_slots];
	logic [7:0] wr_data;
	logic wr_last;
	logic wr_en;
	logic full;

	frame_receiver i_receiver (
		.clk(clk),
		.rst(rst),
		.in_data(in_data),
		.in_data_valid(in_data_valid),
		.in_frame_valid(in_frame_valid),
		.cmd_strobe(cmd_strobe),
		.eid_strobe(eid_strobe),
		.len_strobe(len_strobe),
		.payload_strobe(payload_strobe),
		.byte_data(byte_data),
		.frame_end(frame_end)
	);

	basics_controller i_controller (
		.clk(clk),
		.rst(rst),
		.cmd_strobe(cmd_strobe),
		.eid_strobe(eid_strobe),
		.len_strobe(len_strobe),
		.payload_strobe(payload_strobe),
		.byte_data(byte_data),
		.frame_end(frame_end),
		.reply_busy(reply_busy),
		.slot_sel(slot_sel),
		.stage_shift(stage_shift),
		.stage_byte(stage_byte),
		.commit(commit),
		.reply_start(reply_start),
		.reply_code(reply_code),
		.reply_eid(reply_eid),
		.reply_kind(reply_kind),
		.reply_slot(reply_slot)
	);

	// One slot per setting, only the selected one sees shift and commit
	for (genvar i = 0; i < basics_pkg::num_slots; i++) begin : g_slot
		localparam logic [basics_pkg::slot_index_w-1:0] idx = i;
		logic [basics_pkg::slot_width[i]-1:0] value;

		setting_slot #(
			.width(basics_pkg::slot_width[i]),
			.reset_value(basics_pkg::slot_reset[i])
		) i_slot (
			.clk(clk),
			.rst(rst),
			.shift(stage_shift && slot_sel == idx),
			.commit(commit && slot_sel == idx),
			.shift_byte(stage_byte),
			.value(value)
		);

		assign slot_value[i] = 24'(value);
	end

	response_builder i_builder (
		.clk(clk),
		.rst(rst),
		.reply_start(reply_start),
		.reply_code(reply_code),
		.reply_eid(reply_eid),
		.reply_kind(reply_kind),
		.reply_slot(reply_slot),
		.slot_value(slot_value),
		.full(full),
		.wr_data(wr_data),
		.wr_last(wr_last),
		.wr_en(wr_en),
		.reply_busy(reply_busy)
	);

	message_fifo i_fifo (
		.clk(clk),
		.rst(rst),
		.wr_data(wr_data),
		.wr_last(wr_last),
		.wr_en(wr_en),
		.out_ready(out_ready),
		.full(full),
		.out_data(out_data),
		.out_last(out_last),
		.out_valid(out_valid)
	);

	// Named setting outputs, slot order follows the package table
	assign i2c_speed = slot_value[0][7:0];
	assign i2c_addr = slot_value[1][15:0];
	assign gpio_level = slot_value[2];
	assign gpio_direction = slot_value[3];
	assign mbus_long_addr = slot_value[4][19:0];
	assign mbus_clk_div = slot_value[5][21:0];

endmodule

// File: testbench/basics_tb.sv
`timescale 1ns/1ps

module basics_tb;

	logic clk;
	logic rst;
	logic [7:0] in_data;
	logic in_data_valid;
	logic in_frame_valid;
	logic out_ready;
	logic [7:0] out_data;
	logic out_last;
	logic out_valid;
	logic [7:0] i2c_speed;
	logic [15:0] i2c_addr;
	logic [23:0] gpio_level;
	logic [23:0] gpio_direction;
	logic [19:0] mbus_long_addr;
	logic [21:0] mbus_clk_div;

	// Test table with frames and replies right aligned and the first byte on top
	string test_name [$];
	logic [63:0] frame_bytes [$];
	int frame_len [$];
	logic [47:0] reply_bytes [$];
	int reply_len [$];
	int check_slot [$];
	logic [23:0] check_value [$];

	integer seed;
	int errors;
	int bytes_taken;
	logic table_ready;

	basics_top i_dut (
		.clk(clk),
		.rst(rst),
		.in_data(in_data),
		.in_data_valid(in_data_valid),
		.in_frame_valid(in_frame_valid),
		.out_ready(out_ready),
		.out_data(out_data),
		.out_last(out_last),
		.out_valid(out_valid),
		.i2c_speed(i2c_speed),
		.i2c_addr(i2c_addr),
		.gpio_level(gpio_level),
		.gpio_direction(gpio_direction),
		.mbus_long_addr(mbus_long_addr),
		.mbus_clk_div(mbus_clk_div)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [7:0] byte_of(input logic [63:0] bytes, input int count,
			input int index);
		return bytes[8 * (count - 1 - index) +: 8];
	endfunction

	// Named setting outputs by slot index
	function automatic logic [23:0] setting_of(input int slot);
		case (slot)
			0: return 24'(i2c_speed);
			1: return 24'(i2c_addr);
			2: return gpio_level;
			3: return gpio_direction;
			4: return 24'(mbus_long_addr);
			default: return 24'(mbus_clk_div);
		endcase
	endfunction

	task automatic stop_run(input string why);
		errors++;
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_equal(input string what, input logic [23:0] expected,
			input logic [23:0] actual);
		assert (actual === expected) else
			stop_run($sformatf("CHECK FAILED %s: expected %h, actual %h", what, expected, actual));
	endtask

	task automatic add_test(input string name, input logic [63:0] frame, input int flen,
			input logic [47:0] reply, input int rlen, input int slot, input logic [23:0] value);
		test_name.push_back(name);
		frame_bytes.push_back(frame);
		frame_len.push_back(flen);
		reply_bytes.push_back(reply);
		reply_len.push_back(rlen);
		check_slot.push_back(slot);
		check_value.push_back(value);
	endtask

	// Slot -1 means no setting to look at
	task automatic build_table();
		add_test("query_i2c_speed_reset", 64'h49_01_01_63, 4, 48'h00_01_01_63, 4, 0, 24'd99);
		add_test("version_match", 64'h76_02_02_00_02, 5, 48'h00_02_00, 3, -1, 24'h0);
		add_test("version_mismatch", 64'h76_03_02_01_07, 5, 48'h01_03_02_00_02, 5, -1, 24'h0);
		add_test("set_gpio_level", 64'h67_04_04_6C_12_34_56, 7, 48'h00_04_00, 3, 2, 24'h123456);
		add_test("query_gpio_level", 64'h47_05_01_6C, 4, 48'h00_05_03_12_34_56, 6, -1, 24'h0);
		add_test("set_mbus_div_masked", 64'h6D_06_04_63_FF_AB_CD, 7, 48'h00_06_00, 3, 5,
			24'h3FABCD);
		add_test("query_mbus_div", 64'h4D_07_01_63, 4, 48'h00_07_03_3F_AB_CD, 6, -1, 24'h0);
		add_test("set_gpio_dir_short", 64'h67_08_03_64_11_22, 6, 48'h01_08_00, 3, 3, 24'h0);
		add_test("set_unknown_selector", 64'h69_09_02_7A_55, 5, 48'h01_09_00, 3, 0, 24'd99);
		add_test("unknown_command", 64'h5A_0A_01_63, 4, 48'h01_0A_00, 3, 5, 24'h3FABCD);
		add_test("query_i2c_addr_reset", 64'h49_0B_01_61, 4, 48'h00_0B_02_FF_FF, 5, -1, 24'h0);
		add_test("set_i2c_addr", 64'h69_0C_03_61_BE_EF, 6, 48'h00_0C_00, 3, 1, 24'h00BEEF);
		add_test("query_gpio_dir", 64'h47_0D_01_64, 4, 48'h00_0D_03_00_00_00, 6, -1, 24'h0);
		add_test("query_mbus_addr", 64'h4D_0E_01_6C, 4, 48'h00_0E_03_00_00_00, 6, -1, 24'h0);
	endtask

	task automatic check_reset_values();
		check_equal("reset i2c_speed", 24'd99, setting_of(0));
		check_equal("reset i2c_addr", 24'h00FFFF, setting_of(1));
		check_equal("reset gpio_level", 24'h0, setting_of(2));
		check_equal("reset gpio_direction", 24'h0, setting_of(3));
		check_equal("reset mbus_long_addr", 24'h0, setting_of(4));
		check_equal("reset mbus_clk_div", 24'h1, setting_of(5));
	endtask

	// Starts right after a rising edge and gaps the byte strobes at random
	task automatic send_frame(input int k);
		int i;
		in_frame_valid <= 1'b1;
		for (i = 0; i < frame_len[k]; i++) begin
			while ($random(seed) % 3 == 0) begin
				in_data_valid <= 1'b0;
				@(posedge clk);
			end
			in_data <= byte_of(frame_bytes[k], frame_len[k], i);
			in_data_valid <= 1'b1;
			@(posedge clk);
		end
		in_data_valid <= 1'b0;
		in_frame_valid <= 1'b0;
	endtask

	task automatic drive_frames();
		int k;
		int owed;
		owed = 0;
		for (k = 0; k < test_name.size(); k++) begin
			// Keep FIFO occupancy low so the builder is idle when the next command lands
			while (owed - bytes_taken > 10) begin
				@(posedge clk);
			end
			send_frame(k);
			owed += reply_len[k];
			repeat (12) @(posedge clk);
			if (check_slot[k] >= 0) begin
				check_equal($sformatf("%s setting", test_name[k]), check_value[k],
					setting_of(check_slot[k]));
			end
		end
	endtask

	task automatic collect_replies();
		int k;
		int count;
		logic done;
		for (k = 0; k < test_name.size(); k++) begin
			count = 0;
			done = 1'b0;
			while (!done) begin
				@(posedge clk);
				if (out_valid && out_ready) begin
					assert (count < reply_len[k]) else
						stop_run($sformatf("Reply for %s is longer than %0d bytes",
							test_name[k], reply_len[k]));
					check_equal($sformatf("%s byte %0d", test_name[k], count),
						24'(byte_of(64'(reply_bytes[k]), reply_len[k], count)), 24'(out_data));
					count++;
					bytes_taken++;
					if (out_last) begin
						done = 1'b1;
						check_equal($sformatf("%s reply length", test_name[k]),
							24'(reply_len[k]), 24'(count));
					end
				end
				out_ready <= ($random(seed) & 1) == 1;
			end
		end
	endtask

	initial begin
		seed = 32'h27fd;
		errors = 0;
		bytes_taken = 0;
		table_ready = 1'b0;
		rst = 1'b1;
		in_data = 8'h00;
		in_data_valid = 1'b0;
		in_frame_valid = 1'b0;
		out_ready = 1'b0;
		build_table();
		table_ready = 1'b1;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		check_reset_values();
		fork
			drive_frames();
			collect_replies();
		join
		// The final read pointer step shows up one edge later
		@(posedge clk);
		check_equal("fifo drained", 24'h0, 24'(out_valid));
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	// Watchdog allows the reset plus a budget per table entry
	initial begin
		wait (table_ready);
		repeat (16 + 400 * test_name.size()) @(posedge clk);
		$display("Timeout: replies did not all arrive in time");
		$display("*** FAILED ***");
		$fatal(1, "watchdog expired");
	end

endmodule

// File: files.f
design/basics_pkg.sv
design/frame_receiver.sv
design/basics_controller.sv
design/setting_slot.sv
design/response_builder.sv
design/message_fifo.sv
design/basics_top.sv
testbench/basics_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= basics_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean build

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: build
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "\*\*\* FAILED \*\*\*" $(LOG) || ! grep -q "\*\*\* PASSED \*\*\*" $(LOG); then \
		echo "Simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
